// ==== verilog/mips_config.svh ====
// MIPS core configuration

`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// Data path and address width.
`define MIPS_XLEN 32

// Instruction memory depth in words.
`define MIPS_IMEM_WORDS 64

// Architectural register count.
`define MIPS_NREGS 32

`endif

// ==== verilog/mips_pkg.sv ====
// MIPS core types

package mips_pkg;

    // Primary opcode field, instr[31:26].
    typedef enum logic [5:0] {
        R_TYPE = 6'h00,
        J      = 6'h02,
        BEQ    = 6'h04,
        ADDI   = 6'h08,
        LW     = 6'h23,
        SW     = 6'h2b
    } opcode_e;

    // Function field of R-type words, instr[5:0].
    typedef enum logic [5:0] {
        ADD = 6'h20,
        SUB = 6'h22,
        AND = 6'h24,
        OR  = 6'h25,
        SLT = 6'h2a
    } funct_e;

    // Operation requested from the ALU.
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4
    } alu_op_e;

endpackage

// ==== verilog/mips_ctrl_if.sv ====
// Control bundle interface

`timescale 1ns/1ns
`include "mips_config.svh"

interface mips_ctrl_if;

    mips_pkg::alu_op_e      alu_op;
    logic                   alu_src;      // Immediate as operand B.
    logic                   reg_dst_rd;   // R-type destination.
    logic                   branch;
    logic                   jump;
    logic                   mem_read;
    logic                   mem_write;
    logic                   mem_to_reg;
    logic                   reg_write;
    logic [`MIPS_XLEN-1:0]  sign_imm;
    logic [25:0]            jump_target;
    logic [4:0]             dest_reg;     // Already muxed rt/rd.

    modport decoder (
        output alu_op, alu_src, reg_dst_rd, branch, jump, mem_read, mem_write,
               mem_to_reg, reg_write, sign_imm, jump_target, dest_reg
    );

    modport exec (
        input  alu_op, alu_src, branch, jump, mem_read, mem_write,
               mem_to_reg, reg_write, sign_imm, jump_target, dest_reg
    );

endinterface

// ==== verilog/mips_fetch.sv ====
// Program counter and instruction memory

`timescale 1ns/1ns
`include "mips_config.svh"

module mips_fetch (
    input  logic                                  clk,
    input  logic                                  reset_i,
    input  logic                                  stall_i,
    input  logic [`MIPS_XLEN-1:0]                 next_pc_i,
    input  logic                                  imem_we_i,
    input  logic [$clog2(`MIPS_IMEM_WORDS)-1:0]   imem_addr_i,
    input  logic [31:0]                           imem_data_i,
    output logic [31:0]                           instr_o,
    output logic [`MIPS_XLEN-1:0]                 pc_plus4_o
);

    localparam int IMEM_AW = $clog2(`MIPS_IMEM_WORDS);

    logic [`MIPS_XLEN-1:0] pc_q;
    logic [31:0]           imem [0:`MIPS_IMEM_WORDS-1];

    // PC holds while a bus cycle is pending.
    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q <= '0;
        end else if (!stall_i) begin
            pc_q <= next_pc_i;
        end
    end

    // Load port.
    always_ff @(posedge clk) begin
        if (imem_we_i) begin
            imem[imem_addr_i] <= imem_data_i;
        end
    end

    assign instr_o    = imem[pc_q[IMEM_AW+1:2]];  // Word addressed.
    assign pc_plus4_o = pc_q + `MIPS_XLEN'd4;

    // Branch and jump targets from execute must keep the PC on a word boundary.
    pc_aligned_a : assert property (
        @(posedge clk) disable iff (reset_i)
        pc_q[1:0] == 2'b00
    );

endmodule

// ==== verilog/mips_control.sv ====
// Instruction decoder and main control

`timescale 1ns/1ns
`include "mips_config.svh"

module mips_control (
    input  logic [31:0]          instr_i,
    mips_ctrl_if.decoder         ctrl
);

    localparam int RA_W = $clog2(`MIPS_NREGS);

    logic [5:0]      op_field;
    logic [5:0]      funct_field;
    logic [RA_W-1:0] rt_field;
    logic [RA_W-1:0] rd_field;
    logic [15:0]     imm_field;

    assign op_field    = instr_i[31:26];
    assign rt_field    = instr_i[20:16];
    assign rd_field    = instr_i[15:11];
    assign funct_field = instr_i[5:0];
    assign imm_field   = instr_i[15:0];

    assign ctrl.sign_imm    = {{(`MIPS_XLEN-16){imm_field[15]}}, imm_field};
    assign ctrl.jump_target = instr_i[25:0];
    assign ctrl.dest_reg    = ctrl.reg_dst_rd ? rd_field : rt_field;

    always_comb begin
        // Safe bundle, anything unknown falls through to this.
        ctrl.alu_op     = mips_pkg::ALU_ADD;
        ctrl.alu_src    = 1'b0;
        ctrl.reg_dst_rd = 1'b0;
        ctrl.branch     = 1'b0;
        ctrl.jump       = 1'b0;
        ctrl.mem_read   = 1'b0;
        ctrl.mem_write  = 1'b0;
        ctrl.mem_to_reg = 1'b0;
        ctrl.reg_write  = 1'b0;

        case (mips_pkg::opcode_e'(op_field))
            mips_pkg::R_TYPE: begin
                ctrl.reg_dst_rd = 1'b1;
                ctrl.reg_write  = 1'b1;
                case (mips_pkg::funct_e'(funct_field))
                    mips_pkg::ADD: ctrl.alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::SUB: ctrl.alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::AND: ctrl.alu_op = mips_pkg::ALU_AND;
                    mips_pkg::OR:  ctrl.alu_op = mips_pkg::ALU_OR;
                    mips_pkg::SLT: ctrl.alu_op = mips_pkg::ALU_SLT;
                    default:       ctrl.reg_write = 1'b0;  // Unsupported funct.
                endcase
            end
            mips_pkg::ADDI: begin
                ctrl.alu_src   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            mips_pkg::LW: begin
                ctrl.alu_src    = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.reg_write  = 1'b1;
            end
            mips_pkg::SW: begin
                ctrl.alu_src   = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            mips_pkg::BEQ: begin
                ctrl.alu_op = mips_pkg::ALU_SUB;  // Zero flag means equal.
                ctrl.branch = 1'b1;
            end
            mips_pkg::J: begin
                ctrl.jump = 1'b1;
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== verilog/mips_regfile.sv ====
// Register file

`timescale 1ns/1ns
`include "mips_config.svh"

module mips_regfile (
    input  logic                              clk,
    input  logic                              reset_i,
    input  logic [$clog2(`MIPS_NREGS)-1:0]    rs_addr_i,
    input  logic [$clog2(`MIPS_NREGS)-1:0]    rt_addr_i,
    input  logic                              wr_en_i,
    input  logic [$clog2(`MIPS_NREGS)-1:0]    wr_addr_i,
    input  logic [`MIPS_XLEN-1:0]             wr_data_i,
    output logic [`MIPS_XLEN-1:0]             rs_data_o,
    output logic [`MIPS_XLEN-1:0]             rt_data_o
);

    logic [`MIPS_XLEN-1:0] regs [0:`MIPS_NREGS-1];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < `MIPS_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && (wr_addr_i != '0)) begin
            regs[wr_addr_i] <= wr_data_i;  // r0 never written.
        end
    end

    assign rs_data_o = (rs_addr_i == '0) ? '0 : regs[rs_addr_i];
    assign rt_data_o = (rt_addr_i == '0) ? '0 : regs[rt_addr_i];

    // Execute must hold writeback off while the core sits in reset.
    no_write_in_reset_a : assert property (
        @(posedge clk) reset_i |-> !wr_en_i
    );

endmodule

// ==== verilog/mips_execute.sv ====
// ALU, next PC, bus master and writeback

`timescale 1ns/1ns
`include "mips_config.svh"

module mips_execute (
    input  logic                   clk,
    input  logic                   reset_i,
    mips_ctrl_if.exec              ctrl,
    input  logic [`MIPS_XLEN-1:0]  rs_data_i,
    input  logic [`MIPS_XLEN-1:0]  rt_data_i,
    input  logic [`MIPS_XLEN-1:0]  pc_plus4_i,
    input  logic [`MIPS_XLEN-1:0]  wb_dat_i,
    input  logic                   wb_ack_i,
    output logic [`MIPS_XLEN-1:0]  next_pc_o,
    output logic                   stall_o,
    output logic                   rf_wr_en_o,
    output logic [4:0]             rf_wr_addr_o,
    output logic [`MIPS_XLEN-1:0]  rf_wr_data_o,
    output logic                   wb_cyc_o,
    output logic                   wb_stb_o,
    output logic                   wb_we_o,
    output logic [`MIPS_XLEN-1:0]  wb_adr_o,
    output logic [`MIPS_XLEN-1:0]  wb_dat_o
);

    typedef enum logic {
        BUS_IDLE,
        BUS_WAIT
    } bus_state_e;

    bus_state_e            state_q;
    logic [`MIPS_XLEN-1:0] alu_b;
    logic [`MIPS_XLEN-1:0] alu_result;
    logic                  alu_zero;
    logic [`MIPS_XLEN-1:0] branch_target;
    logic [`MIPS_XLEN-1:0] jump_addr;
    logic                  mem_op;
    logic [`MIPS_XLEN-1:0] adr_q;
    logic [`MIPS_XLEN-1:0] dat_q;
    logic                  we_q;

    // ALU.
    assign alu_b = ctrl.alu_src ? ctrl.sign_imm : rt_data_i;

    always_comb begin
        case (ctrl.alu_op)
            mips_pkg::ALU_ADD: alu_result = rs_data_i + alu_b;
            mips_pkg::ALU_SUB: alu_result = rs_data_i - alu_b;
            mips_pkg::ALU_AND: alu_result = rs_data_i & alu_b;
            mips_pkg::ALU_OR:  alu_result = rs_data_i | alu_b;
            mips_pkg::ALU_SLT: alu_result = {{(`MIPS_XLEN-1){1'b0}},
                                             $signed(rs_data_i) < $signed(alu_b)};
            default:           alu_result = '0;
        endcase
    end

    assign alu_zero = (alu_result == '0);

    // Next PC.
    assign branch_target = pc_plus4_i + (ctrl.sign_imm << 2);
    assign jump_addr     = {pc_plus4_i[`MIPS_XLEN-1:28], ctrl.jump_target, 2'b00};

    always_comb begin
        if (ctrl.jump) begin
            next_pc_o = jump_addr;
        end else if (ctrl.branch && alu_zero) begin
            next_pc_o = branch_target;
        end else begin
            next_pc_o = pc_plus4_i;
        end
    end

    // Wishbone classic master.
    assign mem_op   = (ctrl.mem_read | ctrl.mem_write) & !reset_i;
    assign stall_o  = mem_op & !wb_ack_i;  // Wait for ack.
    assign wb_cyc_o = mem_op;
    assign wb_stb_o = mem_op;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= BUS_IDLE;
        end else begin
            case (state_q)
                BUS_IDLE: if (mem_op && !wb_ack_i) state_q <= BUS_WAIT;
                BUS_WAIT: if (wb_ack_i) state_q <= BUS_IDLE;
                default:  state_q <= BUS_IDLE;
            endcase
        end
    end

    // Request captured on the first cycle, driven from here while waiting.
    always_ff @(posedge clk) begin
        if (state_q == BUS_IDLE) begin
            adr_q <= alu_result;
            dat_q <= rt_data_i;
            we_q  <= ctrl.mem_write;
        end
    end

    assign wb_adr_o = (state_q == BUS_WAIT) ? adr_q : alu_result;
    assign wb_dat_o = (state_q == BUS_WAIT) ? dat_q : rt_data_i;
    assign wb_we_o  = mem_op & ((state_q == BUS_WAIT) ? we_q : ctrl.mem_write);

    // Writeback lands on the same edge as the PC update.
    assign rf_wr_en_o   = ctrl.reg_write & !stall_o & !reset_i;
    assign rf_wr_addr_o = ctrl.dest_reg;
    assign rf_wr_data_o = ctrl.mem_to_reg ? wb_dat_i : alu_result;

    // Request stays up with cyc until the slave acks.
    stb_held_a : assert property (
        @(posedge clk) disable iff (reset_i)
        (wb_stb_o && !wb_ack_i) |=> (wb_stb_o && wb_cyc_o)
    );

    // Stalled fetch and register file must keep the request address steady.
    adr_stable_a : assert property (
        @(posedge clk) disable iff (reset_i)
        (state_q == BUS_WAIT) |-> (alu_result == wb_adr_o)
    );

endmodule

// ==== verilog/mips_top.sv ====
// MIPS single cycle core

`timescale 1ns/1ns
`include "mips_config.svh"

module mips_top (
    input  logic                                 clk,
    input  logic                                 reset_i,
    input  logic                                 imem_we_i,
    input  logic [$clog2(`MIPS_IMEM_WORDS)-1:0]  imem_addr_i,
    input  logic [31:0]                          imem_data_i,
    input  logic [`MIPS_XLEN-1:0]                wb_dat_i,
    input  logic                                 wb_ack_i,
    output logic                                 wb_cyc_o,
    output logic                                 wb_stb_o,
    output logic                                 wb_we_o,
    output logic [`MIPS_XLEN-1:0]                wb_adr_o,
    output logic [`MIPS_XLEN-1:0]                wb_dat_o
);

    logic [31:0]           instr;
    logic [`MIPS_XLEN-1:0] pc_plus4;
    logic [`MIPS_XLEN-1:0] next_pc;
    logic                  stall;
    logic [`MIPS_XLEN-1:0] rs_data;
    logic [`MIPS_XLEN-1:0] rt_data;
    logic                  rf_wr_en;
    logic [4:0]            rf_wr_addr;
    logic [`MIPS_XLEN-1:0] rf_wr_data;

    mips_ctrl_if ctrl_if ();

    mips_fetch u_fetch (
        .clk         (clk),
        .reset_i     (reset_i),
        .stall_i     (stall),
        .next_pc_i   (next_pc),
        .imem_we_i   (imem_we_i),
        .imem_addr_i (imem_addr_i),
        .imem_data_i (imem_data_i),
        .instr_o     (instr),
        .pc_plus4_o  (pc_plus4)
    );

    mips_control u_control (
        .instr_i (instr),
        .ctrl    (ctrl_if.decoder)
    );

    mips_regfile u_regfile (
        .clk       (clk),
        .reset_i   (reset_i),
        .rs_addr_i (instr[25:21]),
        .rt_addr_i (instr[20:16]),
        .wr_en_i   (rf_wr_en),
        .wr_addr_i (rf_wr_addr),
        .wr_data_i (rf_wr_data),
        .rs_data_o (rs_data),
        .rt_data_o (rt_data)
    );

    mips_execute u_execute (
        .clk          (clk),
        .reset_i      (reset_i),
        .ctrl         (ctrl_if.exec),
        .rs_data_i    (rs_data),
        .rt_data_i    (rt_data),
        .pc_plus4_i   (pc_plus4),
        .wb_dat_i     (wb_dat_i),
        .wb_ack_i     (wb_ack_i),
        .next_pc_o    (next_pc),
        .stall_o      (stall),
        .rf_wr_en_o   (rf_wr_en),
        .rf_wr_addr_o (rf_wr_addr),
        .rf_wr_data_o (rf_wr_data),
        .wb_cyc_o     (wb_cyc_o),
        .wb_stb_o     (wb_stb_o),
        .wb_we_o      (wb_we_o),
        .wb_adr_o     (wb_adr_o),
        .wb_dat_o     (wb_dat_o)
    );

endmodule

// ==== bench/mips_checker.sv ====
// Wishbone store checker

`timescale 1ns/1ns
`include "mips_config.svh"

module mips_checker (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  cyc_i,
    input  logic                  stb_i,
    input  logic                  we_i,
    input  logic [`MIPS_XLEN-1:0] adr_i,
    input  logic [`MIPS_XLEN-1:0] dat_i,
    input  logic                  ack_i,
    output logic                  done_o,
    output int                    mismatch_cnt_o,
    output int                    error_cnt_o
);

    localparam int NSTORES       = 10;
    localparam int STORE_TIMEOUT = 60;
    localparam int RESET_TIMEOUT = 200;
    localparam int IDLE_WINDOW   = 40;

    logic [`MIPS_XLEN-1:0] exp_adr [0:NSTORES-1];
    logic [`MIPS_XLEN-1:0] exp_dat [0:NSTORES-1];
    int                    run_errs = 0;
    int                    reset_errs = 0;
    int                    n;
    logic                  got;

    assign error_cnt_o = run_errs + reset_errs;

    task automatic wait_store(output logic seen);
        int k;
        seen = 1'b0;
        k = 0;
        while (!seen && k < STORE_TIMEOUT) begin
            @(posedge clk);
            seen = cyc_i && stb_i && we_i && ack_i;
            k++;
        end
    endtask

    always @(posedge clk) begin
        if (reset_i && cyc_i) begin
            $display("wb_cyc_o went high while reset_i was high");
            reset_errs++;
        end
    end

    initial begin
        done_o         = 1'b0;
        mismatch_cnt_o = 0;
        exp_adr[0] = 32'h100;
        exp_dat[0] = 32'h0000000c;  // 7 + 5.
        exp_adr[1] = 32'h104;
        exp_dat[1] = 32'h00000002;
        exp_adr[2] = 32'h108;
        exp_dat[2] = 32'h00000005;
        exp_adr[3] = 32'h10c;
        exp_dat[3] = 32'h00000007;
        exp_adr[4] = 32'h110;
        exp_dat[4] = 32'h00000001;  // 5 < 7.
        exp_adr[5] = 32'h114;
        exp_dat[5] = 32'hfffffffd;
        exp_adr[6] = 32'h200;
        exp_dat[6] = 32'h00000007;
        exp_adr[7] = 32'h204;
        exp_dat[7] = 32'h00000008;  // Loaded value plus one.
        exp_adr[8] = 32'h304;
        exp_dat[8] = 32'h00000005;
        exp_adr[9] = 32'h30c;
        exp_dat[9] = 32'h00000000;  // r0 after a write to it.

        n = 0;
        while (reset_i && n < RESET_TIMEOUT) begin
            @(posedge clk);
            n++;
        end

        for (int i = 0; i < NSTORES; i++) begin
            wait_store(got);
            if (!got) begin
                $display("store %0d never appeared on the bus", i);
                run_errs++;
                break;
            end
            if (adr_i !== exp_adr[i]) begin
                $display("mismatch wb_adr_o store %0d: got %h expected %h", i, adr_i, exp_adr[i]);
                mismatch_cnt_o++;
            end
            if (dat_i !== exp_dat[i]) begin
                $display("mismatch wb_dat_o store %0d: got %h expected %h", i, dat_i, exp_dat[i]);
                mismatch_cnt_o++;
            end
        end

        // The program parks in a jump to itself.
        for (int i = 0; i < IDLE_WINDOW; i++) begin
            @(posedge clk);
            if (cyc_i) begin
                $display("extra bus cycle to address %h after the final store", adr_i);
                run_errs++;
            end
        end
        done_o = 1'b1;
    end

endmodule

// ==== bench/mips_tb.sv ====
// MIPS core testbench

`timescale 1ns/1ns
`include "mips_config.svh"

module mips_tb;

    localparam int PROG_LEN  = 28;
    localparam int RUN_LIMIT = 2000;

    logic                                 clk;
    logic                                 reset_i;
    logic                                 imem_we_i;
    logic [$clog2(`MIPS_IMEM_WORDS)-1:0]  imem_addr_i;
    logic [31:0]                          imem_data_i;
    logic [`MIPS_XLEN-1:0]                wb_dat_i = '0;
    logic                                 wb_ack_i = 1'b0;
    logic                                 wb_cyc_o;
    logic                                 wb_stb_o;
    logic                                 wb_we_o;
    logic [`MIPS_XLEN-1:0]                wb_adr_o;
    logic [`MIPS_XLEN-1:0]                wb_dat_o;
    logic                                 done;
    int                                   mismatch_cnt;
    int                                   error_cnt;
    int                                   seed = 32'h16aa;
    int                                   delay = 0;
    logic                                 pending = 1'b0;
    int                                   cycles;
    int                                   timeouts;
    logic [31:0]                          prog [0:PROG_LEN-1];
    logic [`MIPS_XLEN-1:0]                dmem [0:255];

    function automatic logic [31:0] rtype_word(mips_pkg::funct_e fn, int rd, int rs, int rt);
        return {mips_pkg::R_TYPE, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
    endfunction

    function automatic logic [31:0] itype_word(mips_pkg::opcode_e op, int rt, int rs, int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    function automatic logic [31:0] jump_word(int target);
        return {mips_pkg::J, target[25:0]};
    endfunction

    mips_top i_dut (
        .clk         (clk),
        .reset_i     (reset_i),
        .imem_we_i   (imem_we_i),
        .imem_addr_i (imem_addr_i),
        .imem_data_i (imem_data_i),
        .wb_dat_i    (wb_dat_i),
        .wb_ack_i    (wb_ack_i),
        .wb_cyc_o    (wb_cyc_o),
        .wb_stb_o    (wb_stb_o),
        .wb_we_o     (wb_we_o),
        .wb_adr_o    (wb_adr_o),
        .wb_dat_o    (wb_dat_o)
    );

    mips_checker u_checker (
        .clk            (clk),
        .reset_i        (reset_i),
        .cyc_i          (wb_cyc_o),
        .stb_i          (wb_stb_o),
        .we_i           (wb_we_o),
        .adr_i          (wb_adr_o),
        .dat_i          (wb_dat_o),
        .ack_i          (wb_ack_i),
        .done_o         (done),
        .mismatch_cnt_o (mismatch_cnt),
        .error_cnt_o    (error_cnt)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // Data memory model, ack after 0 to 3 idle cycles.
    always @(negedge clk) begin
        if (reset_i) begin
            wb_ack_i = 1'b0;
            pending  = 1'b0;
            for (int i = 0; i < 256; i++) begin
                dmem[i] = 32'hc0de0000 ^ (i << 2);
            end
        end else begin
            if (wb_ack_i) begin
                wb_ack_i = 1'b0;  // Cycle closed on the last rising edge.
                pending  = 1'b0;
            end
            if (wb_cyc_o && wb_stb_o) begin
                if (!pending) begin
                    pending = 1'b1;
                    delay   = $random(seed) & 3;
                end
                if (delay == 0) begin
                    wb_ack_i = 1'b1;
                    if (wb_we_o) begin
                        dmem[wb_adr_o[9:2]] = wb_dat_o;
                    end else begin
                        wb_dat_i = dmem[wb_adr_o[9:2]];
                    end
                end else begin
                    delay--;
                end
            end
        end
    end

    initial begin
        reset_i     = 1'b1;
        imem_we_i   = 1'b0;
        imem_addr_i = '0;
        imem_data_i = '0;
        timeouts    = 0;
        prog[0]  = itype_word(mips_pkg::LW, 10, 0, 'h0f0);  // Memory op at PC 0 in reset.
        prog[1]  = itype_word(mips_pkg::ADDI, 1, 0, 7);
        prog[2]  = itype_word(mips_pkg::ADDI, 2, 0, 5);
        prog[3]  = rtype_word(mips_pkg::ADD, 3, 1, 2);
        prog[4]  = itype_word(mips_pkg::SW, 3, 0, 'h100);
        prog[5]  = rtype_word(mips_pkg::SUB, 4, 1, 2);
        prog[6]  = itype_word(mips_pkg::SW, 4, 0, 'h104);
        prog[7]  = rtype_word(mips_pkg::AND, 5, 1, 2);
        prog[8]  = itype_word(mips_pkg::SW, 5, 0, 'h108);
        prog[9]  = rtype_word(mips_pkg::OR, 6, 1, 2);
        prog[10] = itype_word(mips_pkg::SW, 6, 0, 'h10c);
        prog[11] = rtype_word(mips_pkg::SLT, 7, 2, 1);
        prog[12] = itype_word(mips_pkg::SW, 7, 0, 'h110);
        prog[13] = itype_word(mips_pkg::ADDI, 8, 0, -3);
        prog[14] = itype_word(mips_pkg::SW, 8, 0, 'h114);
        prog[15] = itype_word(mips_pkg::SW, 1, 0, 'h200);
        prog[16] = itype_word(mips_pkg::LW, 9, 0, 'h200);
        prog[17] = itype_word(mips_pkg::ADDI, 9, 9, 1);
        prog[18] = itype_word(mips_pkg::SW, 9, 0, 'h204);
        prog[19] = itype_word(mips_pkg::BEQ, 1, 1, 1);  // Taken.
        prog[20] = itype_word(mips_pkg::SW, 1, 0, 'h300);
        prog[21] = itype_word(mips_pkg::BEQ, 2, 1, 1);  // Not taken.
        prog[22] = itype_word(mips_pkg::SW, 2, 0, 'h304);
        prog[23] = jump_word(25);
        prog[24] = itype_word(mips_pkg::SW, 1, 0, 'h308);
        prog[25] = itype_word(mips_pkg::ADDI, 0, 0, 'h55);
        prog[26] = itype_word(mips_pkg::SW, 0, 0, 'h30c);
        prog[27] = jump_word(27);  // Park here.

        for (int i = 0; i < PROG_LEN; i++) begin
            @(negedge clk);
            imem_we_i   = 1'b1;
            imem_addr_i = i[5:0];
            imem_data_i = prog[i];
        end
        @(negedge clk);
        imem_we_i = 1'b0;
        repeat (5) @(negedge clk);
        reset_i = 1'b0;

        cycles = 0;
        while (!done && cycles < RUN_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (!done) begin
            $display("checker did not finish within %0d cycles", RUN_LIMIT);
            timeouts++;
        end

        $display("errors: %0d mismatches, %0d other, %0d timeouts",
                 mismatch_cnt, error_cnt, timeouts);
        if (mismatch_cnt == 0 && error_cnt == 0 && timeouts == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+verilog
verilog/mips_pkg.sv
verilog/mips_ctrl_if.sv
verilog/mips_fetch.sv
verilog/mips_control.sv
verilog/mips_regfile.sv
verilog/mips_execute.sv
verilog/mips_top.sv
bench/mips_checker.sv
bench/mips_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module mips_tb -f filelist.f -o mips_sim

./obj_dir/mips_sim | tee sim.log

if grep -q "^Test OK$" sim.log; then
    exit 0
else
    exit 1
fi
